/* axi_addr_demux.sv */
// ----------------------------
// AXI address demux
// Control window to the registers, the
// rest to the error target
// ----------------------------

`timescale 1ns/1ps

module axi_addr_demux
  import mempool_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Manager side
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  // Control register target
  output axi_req_t  ctrl_req_o,
  input  axi_resp_t ctrl_resp_i,
  // Error target
  output axi_req_t  err_req_o,
  input  axi_resp_t err_resp_i
);

  // Idle, or busy with the recorded target
  typedef enum logic [1:0] {
    RouteIdle,
    RouteCtrl,
    RouteErr
  } route_e;

  route_e rd_state_q, rd_state_d;
  route_e wr_state_q, wr_state_d;
  logic   rd_idle, wr_idle;
  logic   ar_to_ctrl, aw_to_ctrl;
  logic   wr_pair;
  logic   wr_tgt_ready;
  logic   ar_hs, aw_hs, r_hs, b_hs;

  function automatic logic in_ctrl_window(addr_t addr);
    return (addr >= CtrlBaseAddr) && (addr < CtrlEndAddr);
  endfunction

  assign rd_idle    = (rd_state_q == RouteIdle);
  assign wr_idle    = (wr_state_q == RouteIdle);
  assign ar_to_ctrl = in_ctrl_window(slv_req_i.ar.addr);
  assign aw_to_ctrl = in_ctrl_window(slv_req_i.aw.addr);
  assign wr_pair    = slv_req_i.aw_valid & slv_req_i.w_valid;

  // Both targets must take AW and W in the same cycle
  assign wr_tgt_ready = aw_to_ctrl ? (ctrl_resp_i.aw_ready & ctrl_resp_i.w_ready)
                                   : (err_resp_i.aw_ready & err_resp_i.w_ready);

  always_comb begin
    // Payloads go to both, valids and readies are steered below
    ctrl_req_o = slv_req_i;
    err_req_o  = slv_req_i;
    slv_resp_o = '0;

    // Read request, only while no read is outstanding
    ctrl_req_o.ar_valid = rd_idle & slv_req_i.ar_valid & ar_to_ctrl;
    err_req_o.ar_valid  = rd_idle & slv_req_i.ar_valid & ~ar_to_ctrl;
    if (rd_idle) begin
      slv_resp_o.ar_ready = ar_to_ctrl ? ctrl_resp_i.ar_ready : err_resp_i.ar_ready;
    end

    // Write request, AW and W together
    ctrl_req_o.aw_valid = wr_idle & wr_pair & aw_to_ctrl;
    ctrl_req_o.w_valid  = wr_idle & wr_pair & aw_to_ctrl;
    err_req_o.aw_valid  = wr_idle & wr_pair & ~aw_to_ctrl;
    err_req_o.w_valid   = wr_idle & wr_pair & ~aw_to_ctrl;
    slv_resp_o.aw_ready = wr_idle & wr_pair & wr_tgt_ready;
    slv_resp_o.w_ready  = wr_idle & wr_pair & wr_tgt_ready;

    // Responses only from the recorded target
    ctrl_req_o.r_ready = 1'b0;
    err_req_o.r_ready  = 1'b0;
    case (rd_state_q)
      RouteCtrl: begin
        slv_resp_o.r       = ctrl_resp_i.r;
        slv_resp_o.r_valid = ctrl_resp_i.r_valid;
        ctrl_req_o.r_ready = slv_req_i.r_ready;
      end
      RouteErr: begin
        slv_resp_o.r       = err_resp_i.r;
        slv_resp_o.r_valid = err_resp_i.r_valid;
        err_req_o.r_ready  = slv_req_i.r_ready;
      end
      default: ;
    endcase

    ctrl_req_o.b_ready = 1'b0;
    err_req_o.b_ready  = 1'b0;
    case (wr_state_q)
      RouteCtrl: begin
        slv_resp_o.b       = ctrl_resp_i.b;
        slv_resp_o.b_valid = ctrl_resp_i.b_valid;
        ctrl_req_o.b_ready = slv_req_i.b_ready;
      end
      RouteErr: begin
        slv_resp_o.b       = err_resp_i.b;
        slv_resp_o.b_valid = err_resp_i.b_valid;
        err_req_o.b_ready  = slv_req_i.b_ready;
      end
      default: ;
    endcase
  end

  assign ar_hs = slv_req_i.ar_valid & slv_resp_o.ar_ready;
  assign aw_hs = wr_pair & slv_resp_o.aw_ready;
  assign r_hs  = slv_resp_o.r_valid & slv_req_i.r_ready;
  assign b_hs  = slv_resp_o.b_valid & slv_req_i.b_ready;

  // Routing FSMs, one per direction
  always_comb begin
    rd_state_d = rd_state_q;
    wr_state_d = wr_state_q;
    if (rd_idle) begin
      if (ar_hs) rd_state_d = ar_to_ctrl ? RouteCtrl : RouteErr;
    end else if (r_hs) begin
      rd_state_d = RouteIdle;
    end
    if (wr_idle) begin
      if (aw_hs) wr_state_d = aw_to_ctrl ? RouteCtrl : RouteErr;
    end else if (b_hs) begin
      wr_state_d = RouteIdle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_state_q <= RouteIdle;
      wr_state_q <= RouteIdle;
    end else begin
      rd_state_q <= rd_state_d;
      wr_state_q <= wr_state_d;
    end
  end

endmodule

/* axi_cut.sv */
// ----------------------------
// AXI register cut
// One slice per channel, requests forward,
// responses backward
// ----------------------------

`timescale 1ns/1ps

module axi_cut
  import mempool_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Manager facing side
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  // Target facing side
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i
);

  // Write address, forward
  axi_spill_reg #(
    .payload_t(axi_aw_chan_t)
  ) i_aw_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.aw_valid),
    .ready_o (slv_resp_o.aw_ready),
    .data_i  (slv_req_i.aw),
    .valid_o (mst_req_o.aw_valid),
    .ready_i (mst_resp_i.aw_ready),
    .data_o  (mst_req_o.aw)
  );

  // Write data, forward
  axi_spill_reg #(
    .payload_t(axi_w_chan_t)
  ) i_w_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.w_valid),
    .ready_o (slv_resp_o.w_ready),
    .data_i  (slv_req_i.w),
    .valid_o (mst_req_o.w_valid),
    .ready_i (mst_resp_i.w_ready),
    .data_o  (mst_req_o.w)
  );

  // Write response, backward
  axi_spill_reg #(
    .payload_t(axi_b_chan_t)
  ) i_b_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mst_resp_i.b_valid),
    .ready_o (mst_req_o.b_ready),
    .data_i  (mst_resp_i.b),
    .valid_o (slv_resp_o.b_valid),
    .ready_i (slv_req_i.b_ready),
    .data_o  (slv_resp_o.b)
  );

  // Read address, forward
  axi_spill_reg #(
    .payload_t(axi_ar_chan_t)
  ) i_ar_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.ar_valid),
    .ready_o (slv_resp_o.ar_ready),
    .data_i  (slv_req_i.ar),
    .valid_o (mst_req_o.ar_valid),
    .ready_i (mst_resp_i.ar_ready),
    .data_o  (mst_req_o.ar)
  );

  // Read data, backward
  axi_spill_reg #(
    .payload_t(axi_r_chan_t)
  ) i_r_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mst_resp_i.r_valid),
    .ready_o (mst_req_o.r_ready),
    .data_i  (mst_resp_i.r),
    .valid_o (slv_resp_o.r_valid),
    .ready_i (slv_req_i.r_ready),
    .data_o  (slv_resp_o.r)
  );

endmodule

/* axi_err_slv.sv */
// ----------------------------
// Error target
// Answers every read and write with
// DECERR, one cycle after the handshake
// ----------------------------

`timescale 1ns/1ps

module axi_err_slv
  import mempool_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axi_req_t  axi_req_i,
  output axi_resp_t axi_resp_o
);

  logic r_pend_q;
  logic b_pend_q;
  id_t  r_id_q;
  id_t  b_id_q;
  logic ar_take;
  logic aw_take;

  // One response per direction at a time
  assign ar_take = axi_req_i.ar_valid & ~r_pend_q;
  // AW and W only as a pair
  assign aw_take = axi_req_i.aw_valid & axi_req_i.w_valid & ~b_pend_q;

  always_comb begin
    axi_resp_o          = '0;
    axi_resp_o.ar_ready = ~r_pend_q;
    axi_resp_o.r_valid  = r_pend_q;
    axi_resp_o.r.id     = r_id_q;
    axi_resp_o.r.resp   = RespDecErr;
    axi_resp_o.r.last   = 1'b1;
    axi_resp_o.aw_ready = aw_take;
    axi_resp_o.w_ready  = aw_take;
    axi_resp_o.b_valid  = b_pend_q;
    axi_resp_o.b.id     = b_id_q;
    axi_resp_o.b.resp   = RespDecErr;
  end

  // Pending flags, cleared on the response handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_pend_q <= 1'b0;
      b_pend_q <= 1'b0;
    end else begin
      if (ar_take) begin
        r_pend_q <= 1'b1;
      end else if (r_pend_q && axi_req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
      if (aw_take) begin
        b_pend_q <= 1'b1;
      end else if (b_pend_q && axi_req_i.b_ready) begin
        b_pend_q <= 1'b0;
      end
    end
  end

  // Echoed ids
  always_ff @(posedge clk_i) begin
    if (ar_take) begin
      r_id_q <= axi_req_i.ar.id;
    end
    if (aw_take) begin
      b_id_q <= axi_req_i.aw.id;
    end
  end

endmodule

/* axi_spill_reg.sv */
// ----------------------------
// One-entry register slice for a
// single valid/ready channel
// ----------------------------

`timescale 1ns/1ps

module axi_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Input side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Output side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // Take an item when empty, or when the held one leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  // Occupancy flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      // Drained without refill
      full_q <= 1'b0;
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  // Registered output, one cycle after the input handshake
  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

/* ctrl_registers.sv */
// ----------------------------
// Read-only control registers
// TCDM bounds and core count behind an
// AXI cut, writes rejected with SLVERR
// ----------------------------

`timescale 1ns/1ps

module ctrl_registers
  import mempool_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // AXI target port
  input  axi_req_t  axi_req_i,
  output axi_resp_t axi_resp_o,
  // Register values for the cluster
  output data_t     tcdm_start_address_o,
  output data_t     tcdm_end_address_o,
  output data_t     num_cores_o
);

  // Field order gives index 0 at the low end
  typedef struct packed {
    data_t num_cores;
    data_t tcdm_end_address;
    data_t tcdm_start_address;
  } ctrl_regs_t;

  ctrl_regs_t                ctrl_regs;
  data_t [NumCtrlRegs-1:0]   reg_file;
  axi_req_t                  req;
  axi_resp_t                 resp;
  addr_t                     word_idx;
  logic                      wr_pair;

  // Constant register contents
  assign ctrl_regs = '{
    tcdm_start_address: TcdmBaseAddr,
    tcdm_end_address:   TcdmEndAddr,
    num_cores:          NumCores
  };

  // Same bits, viewed as an indexable array
  assign reg_file = ctrl_regs;

  assign tcdm_start_address_o = ctrl_regs.tcdm_start_address;
  assign tcdm_end_address_o   = ctrl_regs.tcdm_end_address;
  assign num_cores_o          = ctrl_regs.num_cores;

  // Request and response cut, one cycle each way
  axi_cut i_axi_cut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .slv_req_i  (axi_req_i),
    .slv_resp_o (axi_resp_o),
    .mst_req_o  (req),
    .mst_resp_i (resp)
  );

  // Word index inside the window, aliases repeat every window size
  assign word_idx = (req.ar.addr & CtrlAddrMask) >> 2;

  assign wr_pair = req.aw_valid & req.w_valid;

  always_comb begin
    resp = '0;

    // Write: AW and W leave the cut together with the error response
    resp.b.id     = req.aw.id;
    resp.b.resp   = RespSlvErr;
    resp.b_valid  = wr_pair;
    resp.aw_ready = wr_pair & req.b_ready;
    resp.w_ready  = wr_pair & req.b_ready;

    // Read: answer in the same cycle the request leaves the cut
    resp.r.id    = req.ar.id;
    resp.r.last  = 1'b1;
    resp.r_valid = req.ar_valid;
    if (word_idx < NumCtrlRegs) begin
      resp.r.data = reg_file[word_idx[CtrlIdxWidth-1:0]];
      resp.r.resp = RespOkay;
    end else begin
      // Past the last register, data stays zero
      resp.r.resp = RespSlvErr;
    end

    // Pop AR only when the response is taken
    resp.ar_ready = req.ar_valid & req.r_ready;
  end

endmodule

/* ctrl_subsystem_chk.sv */
// ----------------------------
// AXI handshake assertions, bound
// to the control subsystem ports
// ----------------------------

`timescale 1ns/1ps

module ctrl_subsystem_chk
  import mempool_ctrl_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input axi_req_t  req_i,
  input axi_resp_t resp_i
);

  // Stalled requests keep valid and payload
  ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.ar_valid && !resp_i.ar_ready |=> req_i.ar_valid && $stable(req_i.ar))
    else $error("AR request dropped or changed before ready");

  aw_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.aw_valid && !resp_i.aw_ready |=> req_i.aw_valid && $stable(req_i.aw))
    else $error("AW request dropped or changed before ready");

  // Stalled responses keep valid and payload
  r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.r_valid && !req_i.r_ready |=> resp_i.r_valid && $stable(resp_i.r))
    else $error("R response dropped or changed before ready");

  b_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid && $stable(resp_i.b))
    else $error("B response dropped or changed before ready");

  // A reset cycle leaves no response pending
  rst_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |=> !resp_i.r_valid && !resp_i.b_valid)
    else $error("Response valid high after a reset cycle");

  // Single-beat reads
  r_last_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.r_valid |-> resp_i.r.last)
    else $error("R beat without last");

endmodule

bind ctrl_subsystem_top ctrl_subsystem_chk i_ctrl_subsystem_chk (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (axi_req_i),
  .resp_i  (axi_resp_o)
);

/* ctrl_subsystem_top.sv */
// ----------------------------
// Control subsystem top
// Demux, control registers and error
// target, register values exported
// ----------------------------

`timescale 1ns/1ps

module ctrl_subsystem_top
  import mempool_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // External manager
  input  axi_req_t  axi_req_i,
  output axi_resp_t axi_resp_o,
  // Register values for the cluster
  output data_t     tcdm_start_address_o,
  output data_t     tcdm_end_address_o,
  output data_t     num_cores_o
);

  axi_req_t  ctrl_req;
  axi_resp_t ctrl_resp;
  axi_req_t  err_req;
  axi_resp_t err_resp;

  // Address decode, no added latency
  axi_addr_demux i_axi_addr_demux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slv_req_i   (axi_req_i),
    .slv_resp_o  (axi_resp_o),
    .ctrl_req_o  (ctrl_req),
    .ctrl_resp_i (ctrl_resp),
    .err_req_o   (err_req),
    .err_resp_i  (err_resp)
  );

  // Two cycles through the cut
  ctrl_registers i_ctrl_registers (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .axi_req_i            (ctrl_req),
    .axi_resp_o           (ctrl_resp),
    .tcdm_start_address_o (tcdm_start_address_o),
    .tcdm_end_address_o   (tcdm_end_address_o),
    .num_cores_o          (num_cores_o)
  );

  // Outside the window
  axi_err_slv i_axi_err_slv (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axi_req_i  (err_req),
    .axi_resp_o (err_resp)
  );

endmodule

/* flist.f */
mempool_ctrl_pkg.sv
axi_spill_reg.sv
axi_cut.sv
ctrl_registers.sv
axi_err_slv.sv
axi_addr_demux.sv
ctrl_subsystem_top.sv
ctrl_subsystem_chk.sv
tb_ctrl_subsystem.sv

/* golden_ctrl_vectors.txt */
# op addr     wdata    exp_rdata exp_resp   (all hex, op R = read, W = write)
# exp_resp 0 OKAY, 2 SLVERR, 3 DECERR; exp_rdata is ignored for writes
R 40000000 00000000 00000000 0
R 40000004 00000000 00100000 0
R 40000008 00000000 00000100 0
R 4000000C 00000000 00000000 2
R 40000010 00000000 00000000 2
R 40000FF0 00000000 00000000 2
R 40000FFC 00000000 00000000 2
W 40000000 DEADBEEF 00000000 2
W 40000008 12345678 00000000 2
W 40000FFC A5A5A5A5 00000000 2
R 40000008 00000000 00000100 0
R 40000000 00000000 00000000 0
R 3FFFFFFC 00000000 00000000 3
R 40001000 00000000 00000000 3
R 00000000 00000000 00000000 3
R FFFFFFFC 00000000 00000000 3
W 40001000 0BADF00D 00000000 3
W 80000000 CAFEF00D 00000000 3
W 3FFFFFFC 11111111 00000000 3
R 40000004 00000000 00100000 0
R 80000010 00000000 00000000 3
W 40000004 00000001 00000000 2

/* mempool_ctrl_pkg.sv */
// ----------------------------
// Control subsystem package
// Bus widths, AXI channel structs, response
// codes and the control memory map
// ----------------------------

package mempool_ctrl_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [1:0]           resp_t;

  // AXI response codes (EXOKAY unused)
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;
  localparam resp_t RespDecErr = 2'b11;

  // Single-beat channels, no burst length
  typedef struct packed {
    id_t   id;
    addr_t addr;
  } axi_aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } axi_b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } axi_ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } axi_r_chan_t;

  // Manager side of the bus
  typedef struct packed {
    axi_aw_chan_t aw;
    logic         aw_valid;
    axi_w_chan_t  w;
    logic         w_valid;
    logic         b_ready;
    axi_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } axi_req_t;

  // Target side of the bus
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    axi_b_chan_t b;
    logic        b_valid;
    logic        ar_ready;
    axi_r_chan_t r;
    logic        r_valid;
  } axi_resp_t;

  // Control window, size must be a power of two
  localparam addr_t CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlEndAddr  = 32'h4000_1000;
  localparam addr_t CtrlAddrMask = CtrlEndAddr - CtrlBaseAddr - 1;

  // Register file layout
  localparam int unsigned NumCtrlRegs  = 3;
  localparam int unsigned CtrlIdxWidth = $clog2(NumCtrlRegs);

  // Register values seen by the cluster
  localparam data_t TcdmBaseAddr = 32'h0000_0000;
  localparam data_t TcdmSize     = 32'h0010_0000;
  localparam data_t TcdmEndAddr  = TcdmBaseAddr + TcdmSize;
  localparam data_t NumCores     = 32'd256;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the control subsystem testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ctrl_subsystem \
  -f flist.f -o Vtb_ctrl_subsystem > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_ctrl_subsystem > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* tb_ctrl_subsystem.sv */
// ------------------------------
// Control subsystem testbench
// Replays the golden vectors through the
// top level with random B/R back-pressure
// ------------------------------

`timescale 1ns/1ps

module tb_ctrl_subsystem
  import mempool_ctrl_pkg::*;
();

  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 4;
  localparam int CyclesPerVec = 40;

  logic      clk;
  logic      rst_n;
  axi_req_t  axi_req;
  axi_resp_t axi_resp;
  data_t     tcdm_start;
  data_t     tcdm_end;
  data_t     num_cores;

  // Golden vectors with one entry per transaction
  logic [7:0] vec_op[$];
  addr_t      vec_addr[$];
  data_t      vec_wdata[$];
  data_t      vec_rdata[$];
  resp_t      vec_resp[$];
  logic       vecs_loaded = 1'b0;

  int seed = 57644;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int load_errors;

  ctrl_subsystem_top uut (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .axi_req_i            (axi_req),
    .axi_resp_o           (axi_resp),
    .tcdm_start_address_o (tcdm_start),
    .tcdm_end_address_o   (tcdm_end),
    .num_cores_o          (num_cores)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input int idx, input string label);
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %0d %s: ok", idx, label);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", idx, label, test_errors);
    end
  endtask

  // Lines starting with # are column notes
  task automatic load_vectors();
    int         fd;
    int         code;
    string      line;
    logic [7:0] op;
    addr_t      addr;
    data_t      wdata;
    data_t      rdata;
    resp_t      resp;
    fd = $fopen("golden_ctrl_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file golden_ctrl_vectors.txt");
      load_errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, rdata, resp);
      if (code != 5) begin
        $display("Vector line could not be parsed: %s", line);
        load_errors++;
        continue;
      end
      vec_op.push_back(op);
      vec_addr.push_back(addr);
      vec_wdata.push_back(wdata);
      vec_rdata.push_back(rdata);
      vec_resp.push_back(resp);
    end
    $fclose(fd);
  endtask

  // Called and returns right after a rising edge
  task automatic run_read(input addr_t addr, input id_t id, output axi_r_chan_t r,
                          output int lat);
    axi_r_chan_t first;
    logic        seen;
    logic        done;
    int          n;
    int          rnd;
    seen  = 1'b0;
    done  = 1'b0;
    n     = 0;
    lat   = 0;
    first = '0;
    axi_req.ar.id    <= id;
    axi_req.ar.addr  <= addr;
    axi_req.ar_valid <= 1'b1;
    // AR stays up until the handshake edge
    do begin
      @(posedge clk);
    end while (!axi_resp.ar_ready);
    axi_req.ar_valid <= 1'b0;
    while (!done) begin
      rnd = $random(seed);
      axi_req.r_ready <= rnd[0];
      @(posedge clk);
      n++;
      if (axi_resp.r_valid) begin
        if (!seen) begin
          seen  = 1'b1;
          lat   = n;
          first = axi_resp.r;
        end
        // Payload must not move while stalled
        check_value("r held", 64'(first), 64'(axi_resp.r));
        done = axi_req.r_ready;
      end
    end
    r = axi_resp.r;
    axi_req.r_ready <= 1'b0;
    @(posedge clk);
    check_value("r_valid after handshake", 64'd0, 64'(axi_resp.r_valid));
  endtask

  task automatic run_write(input addr_t addr, input data_t data, input id_t id,
                           output axi_b_chan_t b, output int lat);
    axi_b_chan_t first;
    logic        seen;
    logic        done;
    int          n;
    int          rnd;
    seen  = 1'b0;
    done  = 1'b0;
    n     = 0;
    lat   = 0;
    first = '0;
    axi_req.aw.id    <= id;
    axi_req.aw.addr  <= addr;
    axi_req.aw_valid <= 1'b1;
    axi_req.w.data   <= data;
    axi_req.w.strb   <= '1;
    axi_req.w.last   <= 1'b1;
    axi_req.w_valid  <= 1'b1;
    // AW and W leave together
    do begin
      @(posedge clk);
    end while (!(axi_resp.aw_ready && axi_resp.w_ready));
    axi_req.aw_valid <= 1'b0;
    axi_req.w_valid  <= 1'b0;
    while (!done) begin
      rnd = $random(seed);
      axi_req.b_ready <= rnd[0];
      @(posedge clk);
      n++;
      if (axi_resp.b_valid) begin
        if (!seen) begin
          seen  = 1'b1;
          lat   = n;
          first = axi_resp.b;
        end
        check_value("b held", 64'(first), 64'(axi_resp.b));
        done = axi_req.b_ready;
      end
    end
    b = axi_resp.b;
    axi_req.b_ready <= 1'b0;
    @(posedge clk);
    check_value("b_valid after handshake", 64'd0, 64'(axi_resp.b_valid));
  endtask

  initial begin : main
    axi_r_chan_t r;
    axi_b_chan_t b;
    int          lat;
    int          exp_lat;
    id_t         id;
    axi_req      = '0;
    rst_n        = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    load_errors  = 0;
    id           = '0;
    load_vectors();
    if (vec_op.size() == 0) begin
      $display("No vectors were loaded from golden_ctrl_vectors.txt");
      load_errors++;
    end
    vecs_loaded = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Register values exported to the cluster
    test_errors = 0;
    check_value("tcdm_start_address_o", 64'(TcdmBaseAddr), 64'(tcdm_start));
    check_value("tcdm_end_address_o", 64'(TcdmEndAddr), 64'(tcdm_end));
    check_value("num_cores_o", 64'(NumCores), 64'(num_cores));
    finish_test(0, "exported registers");

    foreach (vec_op[i]) begin
      test_errors = 0;
      // DECERR comes from the error target alone, all else passes two cuts
      exp_lat = (vec_resp[i] == RespDecErr) ? 1 : 2;
      if (vec_op[i] == "R") begin
        run_read(vec_addr[i], id, r, lat);
        check_value("r.id", 64'(id), 64'(r.id));
        check_value("r.data", 64'(vec_rdata[i]), 64'(r.data));
        check_value("r.resp", 64'(vec_resp[i]), 64'(r.resp));
        check_value("r.last", 64'd1, 64'(r.last));
        check_value("r latency", 64'(exp_lat), 64'(lat));
      end else if (vec_op[i] == "W") begin
        run_write(vec_addr[i], vec_wdata[i], id, b, lat);
        check_value("b.id", 64'(id), 64'(b.id));
        check_value("b.resp", 64'(vec_resp[i]), 64'(b.resp));
        check_value("b latency", 64'(exp_lat), 64'(lat));
      end else begin
        $display("Vector %0d has an unknown operation %c", i + 1, vec_op[i]);
        test_errors++;
      end
      finish_test(i + 1, $sformatf("%c %h", vec_op[i], vec_addr[i]));
      id = id + 1'b1;
    end

    $display("Tests run %0d, passed %0d, failed %0d, load errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, load_errors);
    if (tests_failed == 0 && load_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Budget scales with the number of vectors
  initial begin : watchdog
    wait (vecs_loaded);
    #((vec_op.size() + 1) * CyclesPerVec * ClkPeriod);
    $display("Timeout: the vectors did not complete within %0d cycles",
             (vec_op.size() + 1) * CyclesPerVec);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
